// File: hw/tdc_coarse_counter.sv
`timescale 1ns/100ps
`include "tdc_defines.svh"

module tdc_coarse_counter (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     win_start_i,
    input  logic [`TDC_TOF_W-1:0]    range_i,
    output logic [`TDC_COARSE_W-1:0] count_o,
    output logic                     in_window_o,
    output logic                     win_end_o
);

    logic                     active;
    logic [`TDC_COARSE_W-1:0] limit;   // range in clock periods
    logic                     at_limit;

    assign at_limit    = (count_o == limit);
    assign in_window_o = active && !at_limit;
    assign win_end_o   = active && at_limit;   // one cycle, active drops next edge

    // follow range_i until the window opens, so the value of the start edge is held
    always_ff @(posedge clk) begin
        if (!active && !win_start_i) begin
            limit <= range_i[`TDC_TOF_W-1:`TDC_FINE_W];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            count_o <= '0;
        end else if (win_start_i) begin
            active  <= 1'b1;
            count_o <= '0;
        end else if (active) begin
            if (at_limit) begin
                active <= 1'b0;
            end else begin
                count_o <= count_o + 1'b1;
            end
        end
    end

endmodule

// File: hw/tdc_ctrl.sv
`timescale 1ns/100ps
`include "tdc_defines.svh"

module tdc_ctrl import tdc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic [`TDC_PHASE_W-1:0] phase_i,
    input  logic                    ready_i,
    input  logic [`TDC_IDX_W-1:0]   hit_cnt_i,
    input  logic                    win_end_i,
    output logic                    win_start_o,
    output logic                    clear_o,
    output logic                    calc_go_o,
    output logic [`TDC_PHASE_W-1:0] start_phase_o,
    output logic [`TDC_IDX_W-1:0]   calc_idx_o,
    output logic [`TDC_IDX_W-1:0]   out_idx_o,
    tdc_hit_if.ctrl                 hit,
    input  logic [`TDC_TOF_W-1:0]   tof_i,
    input  logic [`TDC_INT_W-1:0]   int_i,
    output logic [`TDC_TOF_W-1:0]   data_o,
    output logic [`TDC_INT_W-1:0]   int_o,
    output logic [`TDC_IDX_W-1:0]   num_o,
    output logic                    data_last_o,
    output logic                    data_valid_o,
    output logic                    busy_o
);

    tdc_state_e            state;
    logic [`TDC_IDX_W-1:0] num_q;      // hits of this window
    logic [`TDC_IDX_W-1:0] issue_idx;  // next hit into the pipeline
    logic [`TDC_IDX_W-1:0] rd_idx;     // next result out
    logic                  drain;
    logic                  beat_go;
    logic                  beat_last;

    assign hit.idx    = issue_idx;
    assign calc_idx_o = issue_idx;
    assign out_idx_o  = rd_idx;

    // first beat on ready, the rest back to back
    assign beat_go   = ((state == WAIT_READY) && ready_i) || ((state == SEND) && !data_last_o);
    assign beat_last = ({1'b0, rd_idx} + 1'b1) >= {1'b0, num_q};   // also true for num_q 0

    always_ff @(posedge clk) begin
        if ((state == IDLE) && start_i) begin
            start_phase_o <= phase_i;
        end
    end

    // ------------------------------------------------------------
    // state and sequencing
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            busy_o      <= 1'b0;
            win_start_o <= 1'b0;
            clear_o     <= 1'b0;
            calc_go_o   <= 1'b0;
            num_q       <= '0;
            issue_idx   <= '0;
            drain       <= 1'b0;
        end else begin
            win_start_o <= 1'b0;
            clear_o     <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state       <= MEASURE;
                        busy_o      <= 1'b1;
                        win_start_o <= 1'b1;
                        clear_o     <= 1'b1;
                    end
                end
                MEASURE: begin
                    if (win_end_i) begin
                        num_q     <= hit_cnt_i;
                        issue_idx <= '0;
                        drain     <= 1'b0;
                        if (hit_cnt_i == '0) begin
                            state <= WAIT_READY;   // nothing to compute
                        end else begin
                            state     <= CALC;
                            calc_go_o <= 1'b1;
                        end
                    end
                end
                CALC: begin
                    if (calc_go_o) begin
                        if (issue_idx == num_q - 1'b1) begin
                            calc_go_o <= 1'b0;
                        end else begin
                            issue_idx <= issue_idx + 1'b1;
                        end
                    end else if (drain) begin
                        state <= WAIT_READY;   // last result is in the buffer
                    end else begin
                        drain <= 1'b1;
                    end
                end
                WAIT_READY: begin
                    if (ready_i) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (data_last_o) begin
                        state  <= IDLE;
                        busy_o <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // output beats
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_idx       <= '0;
            data_valid_o <= 1'b0;
            data_last_o  <= 1'b0;
            data_o       <= '0;
            int_o        <= '0;
            num_o        <= '0;
        end else if (beat_go) begin
            rd_idx       <= rd_idx + 1'b1;
            data_valid_o <= 1'b1;
            data_last_o  <= beat_last;
            data_o       <= (num_q == '0) ? `TDC_NO_HIT : tof_i;
            int_o        <= (num_q == '0) ? '0 : int_i;
            num_o        <= num_q;
        end else begin
            data_valid_o <= 1'b0;
            data_last_o  <= 1'b0;
            if (state != SEND) begin
                rd_idx <= '0;
            end
        end
    end

endmodule

// File: hw/tdc_defines.svh
`ifndef TDC_DEFINES_SVH
`define TDC_DEFINES_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define TDC_COARSE_W 11       // coarse counter, clock periods
`define TDC_FINE_W   4        // decoded dll phase
`define TDC_TOF_W    15       // coarse and fine together
`define TDC_PHASE_W  16       // dll taps
`define TDC_SPAD_W   16       // 4x4 spad array
`define TDC_INT_W    4        // intensity, saturating

// ------------------------------------------------------------
// hit bookkeeping
// ------------------------------------------------------------
`define TDC_MAX_HITS 3
`define TDC_IDX_W    2        // hit index and hit count
`define TDC_NO_HIT   15'h7fff // data word of an empty window

`endif

// File: hw/tdc_hit_if.sv
`timescale 1ns/100ps
`include "tdc_defines.svh"

// one stored hit, selected by idx
interface tdc_hit_if ();

    logic [`TDC_COARSE_W-1:0] coarse;
    logic [`TDC_PHASE_W-1:0]  phase;   // stop phase code
    logic [`TDC_SPAD_W-1:0]   spad;    // spad enables at the trigger
    logic [`TDC_IDX_W-1:0]    idx;

    modport store (
        input  idx,
        output coarse, phase, spad
    );

    modport calc (
        input  coarse, phase, spad
    );

    modport ctrl (
        output idx
    );

endinterface

// File: hw/tdc_hit_store.sv
`timescale 1ns/100ps
`include "tdc_defines.svh"

module tdc_hit_store (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear_i,
    input  logic                     trigger_i,
    input  logic                     in_window_i,
    input  logic [`TDC_COARSE_W-1:0] count_i,
    input  logic [`TDC_PHASE_W-1:0]  phase_i,
    input  logic [`TDC_SPAD_W-1:0]   spad_i,
    tdc_hit_if.store                 hit,
    output logic [`TDC_IDX_W-1:0]    hit_cnt_o
);

    logic [`TDC_COARSE_W-1:0] coarse_q [`TDC_MAX_HITS];
    logic [`TDC_PHASE_W-1:0]  phase_q  [`TDC_MAX_HITS];
    logic [`TDC_SPAD_W-1:0]   spad_q   [`TDC_MAX_HITS];
    logic [`TDC_IDX_W-1:0]    fill;
    logic                     take;

    // later triggers are dropped once the store is full
    assign take = trigger_i && in_window_i && (fill < `TDC_MAX_HITS);

    // ------------------------------------------------------------
    // capture
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill <= '0;
        end else if (clear_i) begin
            fill <= '0;
        end else if (take) begin
            fill <= fill + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            coarse_q[fill] <= count_i;
            phase_q[fill]  <= phase_i;   // stop phase of this edge
            spad_q[fill]   <= spad_i;
        end
    end

    // ------------------------------------------------------------
    // readback by index
    // ------------------------------------------------------------
    assign hit.coarse = coarse_q[hit.idx];
    assign hit.phase  = phase_q[hit.idx];
    assign hit.spad   = spad_q[hit.idx];

    assign hit_cnt_o = fill;

endmodule

// File: hw/tdc_pkg.sv
package tdc_pkg;

    // controller phases of one measurement
    typedef enum logic [2:0] {
        IDLE,        // waiting for start
        MEASURE,     // range window open
        CALC,        // feeding hits to the result pipeline
        WAIT_READY,  // results ready, receiver not yet
        SEND         // output burst
    } tdc_state_e;

endpackage

// File: hw/tdc_result_calc.sv
`timescale 1ns/100ps
`include "tdc_defines.svh"

module tdc_result_calc (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   calc_go_i,
    input  logic [`TDC_PHASE_W-1:0] start_phase_i,
    tdc_hit_if.calc                hit,
    input  logic [`TDC_IDX_W-1:0]  calc_idx_i,
    input  logic [`TDC_IDX_W-1:0]  rd_idx_i,
    output logic [`TDC_TOF_W-1:0]  tof_o,
    output logic [`TDC_INT_W-1:0]  int_o
);

    localparam int ONES_W = $clog2(`TDC_SPAD_W + 1);
    localparam logic [ONES_W-1:0] INT_MAX = ONES_W'((1 << `TDC_INT_W) - 1);

    logic                     s1_valid;
    logic [`TDC_IDX_W-1:0]    s1_idx;
    logic [`TDC_COARSE_W-1:0] s1_coarse;
    logic [`TDC_FINE_W-1:0]   s1_stop_fine;
    logic [`TDC_FINE_W-1:0]   s1_start_fine;
    logic [ONES_W-1:0]        s1_spad_ones;
    logic [`TDC_TOF_W-1:0]    tof_calc;
    logic [`TDC_INT_W-1:0]    int_calc;
    logic [`TDC_TOF_W-1:0]    tof_buf [`TDC_MAX_HITS];
    logic [`TDC_INT_W-1:0]    int_buf [`TDC_MAX_HITS];

    // ------------------------------------------------------------
    // stage 1: thermometer decode and spad count
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= calc_go_i;
        end
    end

    always_ff @(posedge clk) begin
        if (calc_go_i) begin
            s1_idx        <= calc_idx_i;
            s1_coarse     <= hit.coarse;
            s1_stop_fine  <= `TDC_FINE_W'($countones(hit.phase[`TDC_PHASE_W-2:0]));
            s1_start_fine <= `TDC_FINE_W'($countones(start_phase_i[`TDC_PHASE_W-2:0]));
            s1_spad_ones  <= ONES_W'($countones(hit.spad));
        end
    end

    // ------------------------------------------------------------
    // stage 2: tof, intensity, result buffer
    // ------------------------------------------------------------
    // coarse*16 + stop is just the concatenation, wraps mod 2^15
    assign tof_calc = {s1_coarse, s1_stop_fine}
                    - {{`TDC_COARSE_W{1'b0}}, s1_start_fine};
    assign int_calc = (s1_spad_ones > INT_MAX) ? '1 : s1_spad_ones[`TDC_INT_W-1:0];

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            tof_buf[s1_idx] <= tof_calc;
            int_buf[s1_idx] <= int_calc;
        end
    end

    assign tof_o = tof_buf[rd_idx_i];
    assign int_o = int_buf[rd_idx_i];

endmodule

// File: hw/tdc_top.sv
`timescale 1ns/100ps
`include "tdc_defines.svh"

module tdc_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic                    trigger_i,
    input  logic [`TDC_PHASE_W-1:0] phase_i,
    input  logic [`TDC_SPAD_W-1:0]  spad_i,
    input  logic [`TDC_TOF_W-1:0]   range_i,
    input  logic                    ready_i,
    output logic [`TDC_TOF_W-1:0]   data_o,
    output logic [`TDC_INT_W-1:0]   int_o,
    output logic [`TDC_IDX_W-1:0]   num_o,
    output logic                    data_last_o,
    output logic                    data_valid_o,
    output logic                    busy_o
);

    logic                     win_start;
    logic                     win_clear;
    logic                     win_end;
    logic                     in_window;
    logic [`TDC_COARSE_W-1:0] count;
    logic [`TDC_IDX_W-1:0]    hit_cnt;
    logic                     calc_go;
    logic [`TDC_PHASE_W-1:0]  start_phase;
    logic [`TDC_IDX_W-1:0]    calc_idx;
    logic [`TDC_IDX_W-1:0]    out_idx;
    logic [`TDC_TOF_W-1:0]    res_tof;
    logic [`TDC_INT_W-1:0]    res_int;

    tdc_hit_if hit_bus ();

    // ------------------------------------------------------------
    // window, capture, calculation, control
    // ------------------------------------------------------------
    tdc_coarse_counter u_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .win_start_i (win_start),
        .range_i     (range_i),
        .count_o     (count),
        .in_window_o (in_window),
        .win_end_o   (win_end)
    );

    tdc_hit_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear_i     (win_clear),
        .trigger_i   (trigger_i),
        .in_window_i (in_window),
        .count_i     (count),
        .phase_i     (phase_i),
        .spad_i      (spad_i),
        .hit         (hit_bus.store),
        .hit_cnt_o   (hit_cnt)
    );

    tdc_result_calc u_calc (
        .clk           (clk),
        .rst_n         (rst_n),
        .calc_go_i     (calc_go),
        .start_phase_i (start_phase),
        .hit           (hit_bus.calc),
        .calc_idx_i    (calc_idx),
        .rd_idx_i      (out_idx),
        .tof_o         (res_tof),
        .int_o         (res_int)
    );

    tdc_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .phase_i       (phase_i),
        .ready_i       (ready_i),
        .hit_cnt_i     (hit_cnt),
        .win_end_i     (win_end),
        .win_start_o   (win_start),
        .clear_o       (win_clear),
        .calc_go_o     (calc_go),
        .start_phase_o (start_phase),
        .calc_idx_o    (calc_idx),
        .out_idx_o     (out_idx),
        .hit           (hit_bus.ctrl),
        .tof_i         (res_tof),
        .int_i         (res_int),
        .data_o        (data_o),
        .int_o         (int_o),
        .num_o         (num_o),
        .data_last_o   (data_last_o),
        .data_valid_o  (data_valid_o),
        .busy_o        (busy_o)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tdc_tb -f verilog.f -o tdc_sim

status=0
./obj_dir/tdc_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
exit 0

// File: tests/tdc_assertions.sv
`timescale 1ns/100ps
`include "tdc_defines.svh"

module tdc_assertions (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  data_valid_i,
    input  logic                  data_last_i,
    input  logic                  busy_i,
    input  logic [`TDC_IDX_W-1:0] num_i
);

    int valid_busy_errs = 0;
    int last_valid_errs = 0;
    int num_errs        = 0;
    int gap_errs        = 0;
    int fail_count;

    assign fail_count = valid_busy_errs + last_valid_errs + num_errs + gap_errs;

    // ------------------------------------------------------------
    // output burst framing
    // ------------------------------------------------------------
    a_valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid_i |-> busy_i)
        else begin
            valid_busy_errs++;
            $error("data_valid_o high while busy_o is low");
        end

    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        data_last_i |-> data_valid_i)
        else begin
            last_valid_errs++;
            $error("data_last_o high without data_valid_o");
        end

    // beats back to back, same hit count on each
    a_num_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (data_valid_i && !data_last_i) |=> (data_valid_i && $stable(num_i)))
        else begin
            num_errs++;
            $error("burst broken or num_o changed within a burst");
        end

    a_last_gap: assert property (@(posedge clk) disable iff (!rst_n)
        data_last_i |=> !data_valid_i)
        else begin
            gap_errs++;
            $error("data_valid_o still high after the last beat");
        end

endmodule

// File: tests/tdc_checker.sv
`timescale 1ns/100ps
`include "tdc_defines.svh"

module tdc_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic                    trigger_i,
    input  logic [`TDC_PHASE_W-1:0] phase_i,
    input  logic [`TDC_SPAD_W-1:0]  spad_i,
    input  logic [`TDC_TOF_W-1:0]   range_i,
    input  logic                    ready_i,
    input  logic [`TDC_TOF_W-1:0]   data_i,
    input  logic [`TDC_INT_W-1:0]   int_i,
    input  logic [`TDC_IDX_W-1:0]   num_i,
    input  logic                    data_last_i,
    input  logic                    data_valid_i,
    input  logic                    busy_i,
    output int                      win_pass_o,
    output int                      win_fail_o,
    output int                      mismatch_o
);

    typedef enum {M_IDLE, M_MEAS, M_WAIT, M_SEND} mode_e;

    mode_e                 mode;
    int                    age;         // edges since the start edge
    int                    limit;       // window length in clock periods
    int                    start_fine;
    int                    hits;
    int                    hold;        // edges before ready_i counts
    int                    beat;
    int                    win_idx;
    int                    win_errs;
    logic                  pending;     // window done, line not yet printed
    logic [`TDC_TOF_W-1:0] range_q;
    logic [`TDC_TOF_W-1:0] tof_q [`TDC_MAX_HITS];
    logic [`TDC_INT_W-1:0] int_q [`TDC_MAX_HITS];
    logic                  exp_busy;
    logic                  exp_valid;
    logic                  exp_last;
    logic [`TDC_TOF_W-1:0] exp_data;
    logic [`TDC_INT_W-1:0] exp_int;
    logic [`TDC_IDX_W-1:0] exp_num;

    // ------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------
    function automatic int fine_of(input logic [`TDC_PHASE_W-1:0] code);
        int ones;
        ones = 0;
        for (int i = 0; i < 15; i++) begin   // top tap is not part of the code
            ones += int'(code[i]);
        end
        return ones;
    endfunction

    function automatic logic [`TDC_INT_W-1:0] intensity_of(input logic [`TDC_SPAD_W-1:0] spad);
        int ones;
        ones = 0;
        for (int i = 0; i < `TDC_SPAD_W; i++) begin
            ones += int'(spad[i]);
        end
        return (ones > 15) ? 4'hf : `TDC_INT_W'(ones);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %0s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            win_errs++;
            mismatch_o++;
        end
    endtask

    task automatic emit_beat(input int b);
        exp_valid = 1'b1;
        exp_last  = (hits == 0) || (b == hits - 1);
        exp_num   = `TDC_IDX_W'(hits);
        if (hits == 0) begin
            exp_data = `TDC_NO_HIT;
            exp_int  = '0;
        end else begin
            exp_data = tof_q[b];
            exp_int  = int_q[b];
        end
    endtask

    task automatic report_window();
        $display("window %0d: range 0x%0h, %0d hit(s), %0s", win_idx, range_q, hits,
                 (win_errs == 0) ? "ok" : "mismatch");
        if (win_errs == 0) begin
            win_pass_o++;
        end else begin
            win_fail_o++;
        end
        win_idx++;
        win_errs = 0;
        pending  = 1'b0;
    endtask

    // ------------------------------------------------------------
    // compare last edge's outputs, then step the model
    // ------------------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode       = M_IDLE;
            pending    = 1'b0;
            win_idx    = 0;
            win_errs   = 0;
            win_pass_o = 0;
            win_fail_o = 0;
            mismatch_o = 0;
            exp_busy   = 1'b0;
            exp_valid  = 1'b0;
            exp_last   = 1'b0;
            exp_data   = '0;
            exp_int    = '0;
            exp_num    = '0;
        end else begin
            check_value("busy_o", 32'(busy_i), 32'(exp_busy));
            check_value("data_valid_o", 32'(data_valid_i), 32'(exp_valid));
            check_value("data_last_o", 32'(data_last_i), 32'(exp_last));
            if (exp_valid) begin
                check_value("data_o", 32'(data_i), 32'(exp_data));
                check_value("int_o", 32'(int_i), 32'(exp_int));
                check_value("num_o", 32'(num_i), 32'(exp_num));
            end
            exp_valid = 1'b0;
            exp_last  = 1'b0;
            case (mode)
                M_IDLE: begin
                    if (pending) begin
                        report_window();
                    end
                    if (start_i) begin
                        mode       = M_MEAS;
                        age        = 0;
                        hits       = 0;
                        range_q    = range_i;
                        limit      = int'(range_i) / 16;
                        start_fine = fine_of(phase_i);
                        exp_busy   = 1'b1;
                    end
                end
                M_MEAS: begin
                    age++;
                    if (age >= 2) begin
                        if (age - 2 == limit) begin
                            mode = M_WAIT;
                            hold = (hits == 0) ? 0 : hits + 2;   // pipeline drain
                        end else if (trigger_i && hits < `TDC_MAX_HITS) begin
                            tof_q[hits] = `TDC_TOF_W'((age - 2) * 16 + fine_of(phase_i)
                                                      - start_fine);
                            int_q[hits] = intensity_of(spad_i);
                            hits++;
                        end
                    end
                end
                M_WAIT: begin
                    if (hold > 0) begin
                        hold--;
                    end else if (ready_i) begin
                        emit_beat(0);
                        beat = 1;
                        mode = M_SEND;
                    end
                end
                M_SEND: begin
                    if (beat < hits) begin
                        emit_beat(beat);
                        beat++;
                    end else begin
                        exp_busy = 1'b0;   // edge after the last beat
                        mode     = M_IDLE;
                        pending  = 1'b1;
                    end
                end
                default: mode = M_IDLE;
            endcase
        end
    end

endmodule

// File: tests/tdc_tb.sv
`timescale 1ns/100ps
`include "tdc_defines.svh"

module tdc_tb;

    localparam int N_WIN      = 200;
    localparam int CLK_PERIOD = 10;
    localparam int RANGE_MAX  = 1023;   // up to 63 clock periods per window
    localparam int STALL_MAX  = 12;
    // gap, window, calc, worst ready stall and burst of one window
    localparam int WIN_CYCLES = (RANGE_MAX >> 4) + 2 + `TDC_MAX_HITS + 3
                              + STALL_MAX + 1 + `TDC_MAX_HITS + 4;
    localparam int TIMEOUT_NS = 2 * N_WIN * WIN_CYCLES * CLK_PERIOD;

    logic                    clk;
    logic                    rst_n;
    logic                    start_i;
    logic                    trigger_i;
    logic [`TDC_PHASE_W-1:0] phase_i;
    logic [`TDC_SPAD_W-1:0]  spad_i;
    logic [`TDC_TOF_W-1:0]   range_i;
    logic                    ready_i;
    logic [`TDC_TOF_W-1:0]   data_o;
    logic [`TDC_INT_W-1:0]   int_o;
    logic [`TDC_IDX_W-1:0]   num_o;
    logic                    data_last_o;
    logic                    data_valid_o;
    logic                    busy_o;
    int                      win_pass;
    int                      win_fail;
    int                      mismatches;

    tdc_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .trigger_i    (trigger_i),
        .phase_i      (phase_i),
        .spad_i       (spad_i),
        .range_i      (range_i),
        .ready_i      (ready_i),
        .data_o       (data_o),
        .int_o        (int_o),
        .num_o        (num_o),
        .data_last_o  (data_last_o),
        .data_valid_o (data_valid_o),
        .busy_o       (busy_o)
    );

    tdc_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .trigger_i    (trigger_i),
        .phase_i      (phase_i),
        .spad_i       (spad_i),
        .range_i      (range_i),
        .ready_i      (ready_i),
        .data_i       (data_o),
        .int_i        (int_o),
        .num_i        (num_o),
        .data_last_i  (data_last_o),
        .data_valid_i (data_valid_o),
        .busy_i       (busy_o),
        .win_pass_o   (win_pass),
        .win_fail_o   (win_fail),
        .mismatch_o   (mismatches)
    );

    bind tdc_ctrl tdc_assertions u_assertions (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_valid_i (data_valid_o),
        .data_last_i  (data_last_o),
        .busy_i       (busy_o),
        .num_i        (num_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;   // drive point
    endtask

    task automatic drive_lines(input int density);
        trigger_i = ($urandom_range(0, 99) < density);
        phase_i   = `TDC_PHASE_W'($urandom);
        if ($urandom_range(0, 15) == 0) begin
            spad_i = '1;   // every spad fired
        end else begin
            spad_i = `TDC_SPAD_W'($urandom);
        end
    endtask

    task automatic run_window(input int w);
        int density;
        int gap;
        int stall;
        case (w % 4)
            0:       density = 0;    // empty window
            1:       density = 5;
            2:       density = 25;
            default: density = 80;   // overflow past three hits
        endcase
        gap   = $urandom_range(0, 2);
        stall = 0;
        // triggers here fall outside any window
        repeat (gap) begin
            drive_lines(density);
            next_cycle();
        end
        start_i = 1'b1;
        range_i = `TDC_TOF_W'($urandom_range(0, RANGE_MAX));
        ready_i = ($urandom_range(0, 1) == 1);
        drive_lines(density);
        next_cycle();
        while (busy_o) begin
            drive_lines(density);
            range_i = `TDC_TOF_W'($urandom);       // must not disturb the latched range
            start_i = ($urandom_range(0, 9) == 0);  // ignored while busy
            if (stall > 0) begin
                ready_i = 1'b0;
                stall--;
            end else begin
                ready_i = 1'b1;
                if ($urandom_range(0, 3) == 0) begin
                    stall = $urandom_range(1, STALL_MAX);
                end
            end
            next_cycle();
        end
        start_i = 1'b0;
    endtask

    initial begin
        int assert_fails;
        rst_n     = 1'b0;
        start_i   = 1'b0;
        trigger_i = 1'b0;
        phase_i   = '0;
        spad_i    = '0;
        range_i   = '0;
        ready_i   = 1'b0;
        void'($urandom(32'h1c9d1ee7));
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int w = 0; w < N_WIN; w++) begin
            run_window(w);
        end
        repeat (4) next_cycle();
        assert_fails = DUT.u_ctrl.u_assertions.fail_count;
        if (win_pass + win_fail != N_WIN) begin
            $display("only %0d of %0d windows were completed", win_pass + win_fail, N_WIN);
        end
        $display("summary: %0d windows passed, %0d failed, %0d mismatches, %0d assertion errors",
                 win_pass, win_fail, mismatches, assert_fails);
        if (win_fail == 0 && mismatches == 0 && assert_fails == 0 && win_pass == N_WIN) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, the DUT stopped finishing windows", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/tdc_pkg.sv
hw/tdc_hit_if.sv
hw/tdc_coarse_counter.sv
hw/tdc_hit_store.sv
hw/tdc_result_calc.sv
hw/tdc_ctrl.sv
hw/tdc_top.sv
tests/tdc_assertions.sv
tests/tdc_checker.sv
tests/tdc_tb.sv
